// ==== servant_pkg.sv ====
`default_nettype none

package servant_pkg;

   // --------------------
   // bus widths
   // --------------------
   localparam int WB_AW = 32;              // byte address
   localparam int WB_DW = 32;              // one word per access
   localparam int WB_SW = WB_DW / 8;       // one select bit per byte lane

   // --------------------
   // memory
   // --------------------
   localparam int RAM_DEPTH = 1024;        // in 32-bit words, 4 KiB total
   localparam int RAM_AW = $clog2(RAM_DEPTH);

   // --------------------
   // peripherals
   // --------------------
   localparam int GPIO_W = 8;
   localparam int TIMER_W = 32;

   // --------------------
   // address map
   // --------------------
   // bit 31 splits RAM from I/O, bit 30 picks the I/O target and
   // bit 2 picks the timer register
   localparam int ADR_IO_BIT = 31;
   localparam int ADR_TIMER_BIT = 30;
   localparam int ADR_CMP_BIT = 2;

   typedef enum logic {
      IO_GPIO  = 1'b0,                     // 0x8000_0000
      IO_TIMER = 1'b1                      // 0xC000_0000, +4 for mtimecmp
   } io_sel_e;

endpackage

`default_nettype wire

// ==== servant_wb_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface servant_wb_if;

   import servant_pkg::*;

   logic [WB_AW-1:0] adr;
   logic [WB_DW-1:0] dat;                  // write data, master to slave
   logic [WB_SW-1:0] sel;
   logic             we;
   logic             cyc;                  // held until ack is sampled
   logic [WB_DW-1:0] rdt;                  // valid while ack is high
   logic             ack;                  // single-cycle pulse

   modport master (
      output adr,
      output dat,
      output sel,
      output we,
      output cyc,
      input  rdt,
      input  ack
   );

   modport slave (
      input  adr,
      input  dat,
      input  sel,
      input  we,
      input  cyc,
      output rdt,
      output ack
   );

endinterface

`default_nettype wire

// ==== servant_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module servant_arbiter (
   input  logic                         i_wb_clk,
   servant_wb_if.slave                  dmem_bus,
   input  logic [servant_pkg::WB_AW-1:0] i_ibus_adr,
   input  logic                         i_ibus_cyc,
   output logic [servant_pkg::WB_DW-1:0] o_ibus_rdt,
   output logic                         o_ibus_ack,
   servant_wb_if.master                 mem_bus
);

   import servant_pkg::*;

   logic dbus_grant;

   // the data bus wins whenever it asks, fetches get the RAM otherwise
   assign dbus_grant = dmem_bus.cyc;

   // --------------------
   // request path
   // --------------------
   assign mem_bus.adr = dbus_grant ? dmem_bus.adr : i_ibus_adr;
   assign mem_bus.dat = dmem_bus.dat;      // fetches never write so data can pass through
   assign mem_bus.sel = dbus_grant ? dmem_bus.sel : {WB_SW{1'b1}};
   assign mem_bus.we  = dbus_grant & dmem_bus.we;
   assign mem_bus.cyc = dmem_bus.cyc | i_ibus_cyc;

   // --------------------
   // response path
   // --------------------
   assign dmem_bus.rdt = mem_bus.rdt;
   assign o_ibus_rdt   = mem_bus.rdt;

   assign dmem_bus.ack = mem_bus.ack & dbus_grant;
   assign o_ibus_ack   = mem_bus.ack & i_ibus_cyc & ~dbus_grant;

   // the core never fetches while a load or store is pending, so a fetch
   // could otherwise be silently starved by the data bus
   a_one_master : assert property (
      @(posedge i_wb_clk) !(dmem_bus.cyc && i_ibus_cyc)
   ) else $error("instruction and data bus active in the same cycle");

endmodule

`default_nettype wire

// ==== servant_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module servant_mux (
   input  logic                         i_wb_clk,
   input  logic                         i_arst_n,
   input  logic [servant_pkg::WB_AW-1:0] i_dbus_adr,
   input  logic [servant_pkg::WB_DW-1:0] i_dbus_dat,
   input  logic [servant_pkg::WB_SW-1:0] i_dbus_sel,
   input  logic                         i_dbus_we,
   input  logic                         i_dbus_cyc,
   output logic [servant_pkg::WB_DW-1:0] o_dbus_rdt,
   output logic                         o_dbus_ack,
   servant_wb_if.master                 dmem_bus,
   servant_wb_if.master                 io_bus
);

   import servant_pkg::*;

   logic             io_hit;
   logic             io_ack;
   logic [WB_DW-1:0] io_rdt;

   assign io_hit = i_dbus_adr[ADR_IO_BIT];

   // --------------------
   // RAM side
   // --------------------
   assign dmem_bus.adr = i_dbus_adr;
   assign dmem_bus.dat = i_dbus_dat;
   assign dmem_bus.sel = i_dbus_sel;
   assign dmem_bus.we  = i_dbus_we;
   assign dmem_bus.cyc = i_dbus_cyc & ~io_hit;

   // --------------------
   // I/O side
   // --------------------
   assign io_bus.adr = i_dbus_adr;
   assign io_bus.dat = i_dbus_dat;
   assign io_bus.sel = i_dbus_sel;
   assign io_bus.we  = i_dbus_we;
   // masked in the ack cycle so the peripherals see each write once
   assign io_bus.cyc = i_dbus_cyc & io_hit & ~io_ack;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         io_ack <= 1'b0;
      end else begin
         io_ack <= io_bus.cyc;
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (io_bus.cyc) begin
         io_rdt <= io_bus.rdt;             // peripherals answer combinationally
      end
   end

   assign o_dbus_rdt = io_hit ? io_rdt : dmem_bus.rdt;
   assign o_dbus_ack = io_hit ? io_ack : dmem_bus.ack;

   a_dbus_ack_pulse : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n) o_dbus_ack |=> !o_dbus_ack
   ) else $error("data bus ack held for two cycles");

   a_io_sel_known : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      io_bus.cyc |-> !$isunknown(io_sel_e'(io_bus.adr[ADR_TIMER_BIT]))
   ) else $error("I/O access to an unmapped target");

endmodule

`default_nettype wire

// ==== servant_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module servant_ram (
   input  logic        i_wb_clk,
   input  logic        i_arst_n,
   servant_wb_if.slave mem_bus
);

   import servant_pkg::*;

   logic [WB_DW-1:0]  mem [RAM_DEPTH];
   logic [RAM_AW-1:0] word_adr;
   logic [WB_DW-1:0]  rdt_q;
   logic              ack_q;
   logic              wr_en;

   assign word_adr = mem_bus.adr[RAM_AW+1:2]; // upper address bits alias
   // cyc is still high in the ack cycle, the write happens only once
   assign wr_en = mem_bus.cyc & mem_bus.we & ~ack_q;

   // --------------------
   // storage
   // --------------------
   always_ff @(posedge i_wb_clk) begin
      if (wr_en) begin
         for (int lane = 0; lane < WB_SW; lane++) begin
            if (mem_bus.sel[lane]) begin
               mem[word_adr][lane*8 +: 8] <= mem_bus.dat[lane*8 +: 8];
            end
         end
      end
      rdt_q <= mem[word_adr];              // old data on a write, nobody reads it
   end

   // --------------------
   // handshake
   // --------------------
   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= mem_bus.cyc & ~ack_q;
      end
   end

   assign mem_bus.rdt = rdt_q;
   assign mem_bus.ack = ack_q;

   a_req_held : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      mem_bus.cyc && !mem_bus.ack |=>
         mem_bus.cyc && $stable(mem_bus.adr) && $stable(mem_bus.we)
   ) else $error("RAM request changed before its ack");

endmodule

`default_nettype wire

// ==== servant_io.sv ====
`timescale 1ns/1ns
`default_nettype none

module servant_io (
   input  logic                           i_wb_clk,
   input  logic                           i_arst_n,
   servant_wb_if.slave                    io_bus,
   output logic [servant_pkg::GPIO_W-1:0] o_gpio,
   output logic                           o_timer_irq
);

   import servant_pkg::*;

   io_sel_e            io_sel;
   logic               cmp_sel;
   logic               wr_en;
   logic [GPIO_W-1:0]  gpio_q;
   logic [TIMER_W-1:0] mtime;
   logic [TIMER_W-1:0] mtimecmp;
   logic               irq_q;

   assign io_sel  = io_sel_e'(io_bus.adr[ADR_TIMER_BIT]);
   assign cmp_sel = io_bus.adr[ADR_CMP_BIT];
   assign wr_en   = io_bus.cyc & io_bus.we;

   // --------------------
   // GPIO
   // --------------------
   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         gpio_q <= '0;
      end else if (wr_en && io_sel == IO_GPIO) begin
         gpio_q <= io_bus.dat[GPIO_W-1:0]; // only the low byte is kept
      end
   end

   // --------------------
   // machine timer
   // --------------------
   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime    <= '0;
         mtimecmp <= '1;                   // parked out of reach so no irq after reset
         irq_q    <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;            // free running, wraps silently
         if (wr_en && io_sel == IO_TIMER && cmp_sel) begin
            mtimecmp <= TIMER_W'(io_bus.dat);
         end
         irq_q <= (mtime >= mtimecmp);
      end
   end

   // --------------------
   // read back
   // --------------------
   always_comb begin
      unique case (io_sel)
         IO_GPIO: begin
            io_bus.rdt = {{(WB_DW-GPIO_W){1'b0}}, gpio_q};
         end
         IO_TIMER: begin
            io_bus.rdt = cmp_sel ? WB_DW'(mtimecmp) : WB_DW'(mtime);
         end
         default: begin
            io_bus.rdt = '0;
         end
      endcase
   end

   assign o_gpio      = gpio_q;
   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

// ==== servant_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module servant_soc (
   input  logic                           i_wb_clk,
   input  logic                           i_arst_n,

   input  logic [servant_pkg::WB_AW-1:0]  i_ibus_adr,
   input  logic                           i_ibus_cyc,
   output logic [servant_pkg::WB_DW-1:0]  o_ibus_rdt,
   output logic                           o_ibus_ack,

   input  logic [servant_pkg::WB_AW-1:0]  i_dbus_adr,
   input  logic [servant_pkg::WB_DW-1:0]  i_dbus_dat,
   input  logic [servant_pkg::WB_SW-1:0]  i_dbus_sel,
   input  logic                           i_dbus_we,
   input  logic                           i_dbus_cyc,
   output logic [servant_pkg::WB_DW-1:0]  o_dbus_rdt,
   output logic                           o_dbus_ack,

   output logic [servant_pkg::GPIO_W-1:0] o_q,
   output logic                           o_timer_irq
);

   servant_wb_if dmem_bus ();              // mux to arbiter
   servant_wb_if mem_bus ();               // arbiter to RAM
   servant_wb_if io_bus ();                // mux to peripherals

   // --------------------
   // fabric
   // --------------------
   servant_mux servant_mux_inst (
      .i_wb_clk   (i_wb_clk),
      .i_arst_n   (i_arst_n),
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt),
      .o_dbus_ack (o_dbus_ack),
      .dmem_bus   (dmem_bus.master),
      .io_bus     (io_bus.master)
   );

   servant_arbiter servant_arbiter_inst (
      .i_wb_clk   (i_wb_clk),
      .dmem_bus   (dmem_bus.slave),
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .mem_bus    (mem_bus.master)
   );

   // --------------------
   // slaves
   // --------------------
   servant_ram servant_ram_inst (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .mem_bus  (mem_bus.slave)
   );

   servant_io servant_io_inst (
      .i_wb_clk    (i_wb_clk),
      .i_arst_n    (i_arst_n),
      .io_bus      (io_bus.slave),
      .o_gpio      (o_q),
      .o_timer_irq (o_timer_irq)
   );

endmodule

`default_nettype wire

// ==== tb_servant_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_servant_soc;

   localparam int CLK_PERIOD = 20;
   localparam int DRIVE_DELAY = 2;
   localparam int RESET_CYCLES = 5;
   localparam int ACK_LIMIT = 8;

   localparam logic [3:0] OP_FETCH = 4'h0;
   localparam logic [3:0] OP_READ  = 4'h1;
   localparam logic [3:0] OP_WRITE = 4'h2;
   localparam logic [3:0] OP_WAIT  = 4'h3;   // idle cycles, counts stray acks
   localparam logic [3:0] OP_GPIO  = 4'h4;
   localparam logic [3:0] OP_IRQ   = 4'h5;
   localparam logic [3:0] OP_DELTA = 4'h6;   // mtime read against the previous one

   logic        clk;
   logic        arst_n;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic [3:0]  dbus_sel;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;
   logic [7:0]  o_q;
   logic        o_timer_irq;

   int          q_test[$];
   logic [3:0]  q_op[$];
   logic [31:0] q_adr[$];
   logic [31:0] q_dat[$];
   logic [3:0]  q_sel[$];
   logic [31:0] q_exp[$];
   logic [31:0] shadow [int];                 // expected RAM contents by word address
   logic [31:0] last_mtime;
   int          cur_test;
   int          checks;
   int          test_errors;
   int          total_errors;
   int          tests_passed;
   int          tests_failed;
   bit          loaded;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   servant_soc servant_soc_inst (
      .i_wb_clk    (clk),
      .i_arst_n    (arst_n),
      .i_ibus_adr  (ibus_adr),
      .i_ibus_cyc  (ibus_cyc),
      .o_ibus_rdt  (ibus_rdt),
      .o_ibus_ack  (ibus_ack),
      .i_dbus_adr  (dbus_adr),
      .i_dbus_dat  (dbus_dat),
      .i_dbus_sel  (dbus_sel),
      .i_dbus_we   (dbus_we),
      .i_dbus_cyc  (dbus_cyc),
      .o_dbus_rdt  (dbus_rdt),
      .o_dbus_ack  (dbus_ack),
      .o_q         (o_q),
      .o_timer_irq (o_timer_irq)
   );

   // --------------------
   // helpers
   // --------------------
   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("ERROR at %0t ns: test %0d, %s: got %h, expected %h",
                  $time, cur_test, what, got, exp);
         test_errors++;
         total_errors++;
      end
   endtask

   function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
                                               input logic [3:0] sel);
      logic [31:0] word;
      word = old;
      for (int lane = 0; lane < 4; lane++) begin
         if (sel[lane]) begin
            word[lane*8 +: 8] = dat[lane*8 +: 8];
         end
      end
      return word;
   endfunction

   task automatic realign;
      @(posedge clk);
      #DRIVE_DELAY;                            // every operation starts just after an edge
   endtask

   task automatic bus_access(input bit fetch, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we, output logic [31:0] rdt);
      int cycles;
      bit got_ack;
      cycles = 0;
      got_ack = 1'b0;
      if (fetch) begin
         ibus_adr = adr;
         ibus_cyc = 1'b1;
      end else begin
         dbus_adr = adr;
         dbus_dat = dat;
         dbus_sel = sel;
         dbus_we  = we;
         dbus_cyc = 1'b1;
      end
      while (!got_ack && cycles < ACK_LIMIT) begin
         @(negedge clk);                       // the first one still falls in the request cycle
         cycles++;
         got_ack = fetch ? ibus_ack : dbus_ack;
      end
      if (!got_ack) begin
         $display("test %0d: no ack came back for address %h", cur_test, adr);
      end
      rdt = fetch ? ibus_rdt : dbus_rdt;
      check_value(32'(cycles - 1), 32'd1, "ack latency in cycles");
      realign();
      ibus_cyc = 1'b0;
      dbus_cyc = 1'b0;
      dbus_we  = 1'b0;
   endtask

   task automatic wait_idle(input int cycles, input logic [31:0] exp_acks);
      int acks;
      acks = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (ibus_ack || dbus_ack) begin
            acks++;
         end
      end
      check_value(32'(acks), exp_acks, "acks seen while idle");
      realign();
   endtask

   task automatic wait_irq(input int max_cycles, input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (o_timer_irq !== level && n < max_cycles);
      check_value(32'(o_timer_irq), 32'(level), $sformatf("timer irq after %0d cycles", n));
      realign();
   endtask

   task automatic run_op(input logic [3:0] op, input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel, input logic [31:0] exp);
      logic [31:0] rdt;
      int key;
      key = int'(adr[11:2]);
      case (op)
         OP_FETCH, OP_READ: begin
            bus_access(op == OP_FETCH, adr, '0, sel, 1'b0, rdt);
            check_value(rdt, exp, "read data");
            if (!adr[31] && shadow.exists(key)) begin
               check_value(rdt, shadow[key], "read data against RAM model");
            end
         end
         OP_WRITE: begin
            bus_access(1'b0, adr, dat, sel, 1'b1, rdt);
            if (!adr[31]) begin
               shadow[key] = merge_lanes(shadow.exists(key) ? shadow[key] : '0, dat, sel);
            end
         end
         OP_WAIT: wait_idle(int'(dat), exp);
         OP_GPIO: begin
            @(negedge clk);
            check_value({24'b0, o_q}, exp, "GPIO output");
            realign();
         end
         OP_IRQ: wait_irq(int'(dat), exp[0]);
         OP_DELTA: begin
            bus_access(1'b0, adr, '0, sel, 1'b0, rdt);
            check_value(32'(rdt > last_mtime), 32'd1, "mtime larger than the previous read");
            check_value(32'((rdt - last_mtime) >= exp), 32'd1,
                        $sformatf("mtime advanced by %0d", rdt - last_mtime));
            last_mtime = rdt;
         end
         default: begin
            $display("test %0d: unknown operation %h in the stim file", cur_test, op);
            test_errors++;
            total_errors++;
         end
      endcase
   endtask

   task automatic finish_test;
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d finished: %0d checks ok", cur_test, checks);
      end else begin
         tests_failed++;
         $display("test %0d finished: %0d of %0d checks failed", cur_test, test_errors, checks);
      end
      checks = 0;
      test_errors = 0;
   endtask

   task automatic load_stim(output bit ok);
      int fd;
      int n;
      int t;
      string line;
      logic [3:0]  op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [31:0] exp;
      ok = 1'b0;
      fd = $fopen("servant_stim.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
               continue;                       // blank or comment line
            end
            n = $sscanf(line, "%d %h %h %h %h %h", t, op, adr, dat, sel, exp);
            if (n == 6) begin
               q_test.push_back(t);
               q_op.push_back(op);
               q_adr.push_back(adr);
               q_dat.push_back(dat);
               q_sel.push_back(sel);
               q_exp.push_back(exp);
            end
         end
         $fclose(fd);
         ok = q_test.size() > 0;
      end
      loaded = 1'b1;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin : main
      bit ok;
      arst_n   = 1'b0;
      ibus_adr = '0;
      ibus_cyc = 1'b0;
      dbus_adr = '0;
      dbus_dat = '0;
      dbus_sel = '0;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b0;
      last_mtime = '0;
      checks = 0;
      test_errors = 0;
      total_errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      loaded = 1'b0;
      load_stim(ok);
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      realign();
      if (!ok) begin
         $display("could not read any operation from servant_stim.txt");
      end else begin
         cur_test = q_test[0];
         foreach (q_test[i]) begin
            if (q_test[i] != cur_test) begin
               finish_test();
               cur_test = q_test[i];
            end
            run_op(q_op[i], q_adr[i], q_dat[i], q_sel[i], q_exp[i]);
         end
         finish_test();
      end
      $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
               tests_passed, tests_failed, total_errors);
      if (ok && tests_failed == 0 && total_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      wait (loaded);
      repeat (q_test.size() * 10 + 200) @(posedge clk);
      $display("simulation timed out before all bus operations completed");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== servant_stim.txt ====
# test op adr data sel expected, all hex except the decimal test number
# op 0 fetch, 1 read, 2 write, 3 idle cycles, 4 GPIO pins, 5 irq level, 6 mtime advance
6 4 00000000 00000000 0 00000000
6 5 00000000 00000001 0 00000000
6 3 00000000 00000008 0 00000000
1 2 00000100 cafef00d f 00000000
1 0 00000100 00000000 0 cafef00d
1 2 00000ffc 0badc0de f 00000000
1 0 00000ffc 00000000 0 0badc0de
1 1 00000100 00000000 f cafef00d
2 2 00000200 11223344 f 00000000
2 2 00000200 aabbccdd 5 00000000
2 1 00000200 00000000 f 11bb33dd
2 2 00000200 99887766 2 00000000
2 1 00000200 00000000 f 11bb77dd
2 0 00000200 00000000 0 11bb77dd
3 2 80000000 000000a5 f 00000000
3 4 00000000 00000000 0 000000a5
3 1 80000000 00000000 f 000000a5
3 2 80000000 12345678 1 00000000
3 4 00000000 00000000 0 00000078
3 1 80000000 00000000 f 00000078
4 2 c0000004 12345678 f 00000000
4 1 c0000004 00000000 f 12345678
4 5 00000000 00000002 0 00000000
4 2 c0000004 00000010 f 00000000
4 5 00000000 00000028 0 00000001
4 2 c0000004 ffffffff f 00000000
4 5 00000000 00000002 0 00000000
5 6 c0000000 00000000 f 00000000
5 3 00000000 0000000a 0 00000000
5 6 c0000000 00000000 f 0000000a

// ==== compile.f ====
servant_pkg.sv
servant_wb_if.sv
servant_arbiter.sv
servant_mux.sv
servant_ram.sv
servant_io.sv
servant_soc.sv
tb_servant_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_servant_soc

rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
   --top-module "$TOP" -f compile.f -o sim_"$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
